//--- Makefile
TOP := tb_uart

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

//--- baud_gen.sv
// Oversampling tick generator module.
`timescale 1ns/1ps

module baud_gen
   (
      input  logic clk,
      input  logic reset,
      output logic tick
   );
   import uart_pkg::*;

   logic [DIV_W-1:0] cnt;
   logic             wrap;

   assign wrap = (cnt == DIV_W'(TICK_DIV - 1));

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         cnt <= '0;
      else if (wrap)
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   assign tick = wrap;   // One cycle high every TICK_DIV cycles.

endmodule

//--- src.f
uart_pkg.sv
baud_gen.sv
tx_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_properties.sv
tb_uart.sv

//--- tb_uart.sv
// UART testbench with clock, reset, loopback and bit-banged receive stimulus.
`timescale 1ns/1ps

module tb_uart;
   import uart_pkg::*;

   localparam int BIT_CYCLES = TICK_DIV * OVERSAMPLE;

   logic        clk;
   logic        reset;
   logic        wr;
   logic [7:0]  wr_data;
   logic        full;
   logic        tx;
   logic        rx;
   logic        loopback;                 // High routes tx straight back into rx.
   logic        rx_line;                  // Serial level driven in direct mode.
   rx_result_t  rx_result;
   logic        rx_valid;
   logic [31:0] rng = 32'h6177;
   logic [7:0]  expected_q[$];
   int          valid_count = 0;
   int          received_total = 0;
   int          kept_count;
   logic        kept;
   logic [7:0]  b;

   assign rx = loopback ? tx : rx_line;

   uart_top i_dut
   (
      .clk       (clk),
      .reset     (reset),
      .wr        (wr),
      .wr_data   (wr_data),
      .full      (full),
      .tx        (tx),
      .rx        (rx),
      .rx_result (rx_result),
      .rx_valid  (rx_valid)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped after a failed check.");
   endtask

   function automatic string error_text(input string what);
      return $sformatf("error at %0t ns: %s", $time, what);
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // The bound checks count their failures, and the run ends at the first one.
   always @(negedge clk)
   begin
      if (rx_valid)
         valid_count++;
      assert (i_dut.i_props.fail_count == 0)
         else stop_with_failure("A bound assertion on the DUT failed.");
   end

   task automatic next_byte(output logic [7:0] value);
      rng   = xorshift32(rng);
      value = rng[7:0];
   endtask

   task automatic write_byte(input logic [7:0] value, output logic taken);
      @(posedge clk);
      #1;
      wr      = 1'b1;
      wr_data = value;
      taken   = !full;   // The queue only takes a byte while not full.
      if (taken)
         expected_q.push_back(value);
   endtask

   task automatic release_write();
      @(posedge clk);
      #1;
      wr = 1'b0;
   endtask

   task automatic wait_tx_start();
      int cycles;
      cycles = 0;
      while (tx && cycles < 2)   // One of the three cycles went by in release_write.
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (!tx) else stop_with_failure("tx did not go low within 3 cycles of a write.");
   endtask

   task automatic check_received(input logic err_exp, input logic [7:0] data_exp);
      int cycles;
      cycles = 0;
      while (!rx_valid && cycles < 1000)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (rx_valid) else stop_with_failure("Timed out waiting for rx_valid.");
      assert (rx_result.data == data_exp)
         else stop_with_failure(error_text($sformatf("received %h, expected %h",
                                                     rx_result.data, data_exp)));
      assert (rx_result.frame_err == err_exp)
         else stop_with_failure(error_text($sformatf("frame_err %b, expected %b",
                                                     rx_result.frame_err, err_exp)));
      received_total++;
      @(posedge clk);   // Step past this pulse.
      #1;
   endtask

   task automatic drive_bit(input logic level);
      rx_line = level;
      repeat (BIT_CYCLES) @(posedge clk);
      #1;
   endtask

   task automatic send_frame(input logic [7:0] value, input logic stop_level);
      drive_bit(1'b0);
      for (int i = 0; i < DATA_BITS; i++)
         drive_bit(value[i]);
      drive_bit(stop_level);
      drive_bit(1'b1);   // One idle bit lets the receiver leave its stop state.
   endtask

   initial
   begin
      reset    = 1'b1;
      wr       = 1'b0;
      wr_data  = '0;
      loopback = 1'b1;
      rx_line  = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (5) @(posedge clk);
      #1;

      next_byte(b);
      write_byte(b, kept);
      release_write();
      wait_tx_start();
      check_received(1'b0, expected_q.pop_front());
      repeat (4 * BIT_CYCLES) @(posedge clk);
      #1;
      assert (valid_count == 1)
         else stop_with_failure(error_text($sformatf("%0d rx_valid pulses, expected 1",
                                                     valid_count)));

      // A lead byte keeps the transmitter busy so the burst fills the queue.
      next_byte(b);
      write_byte(b, kept);
      release_write();
      wait_tx_start();
      kept_count = 0;
      for (int i = 0; i < 6; i++)
      begin
         next_byte(b);
         write_byte(b, kept);
         if (kept)
            kept_count++;
      end
      release_write();
      assert (kept_count == FIFO_DEPTH && full)
         else stop_with_failure(error_text($sformatf("%0d writes taken, full %b",
                                                     kept_count, full)));
      while (expected_q.size() > 0)
         check_received(1'b0, expected_q.pop_front());

      repeat (2 * BIT_CYCLES) @(posedge clk);
      #1;
      loopback = 1'b0;
      next_byte(b);
      fork
         send_frame(b, 1'b0);
         check_received(1'b1, b);
      join
      next_byte(b);
      fork
         send_frame(b, 1'b1);
         check_received(1'b0, b);
      join

      repeat (BIT_CYCLES) @(posedge clk);
      #1;
      if (valid_count != received_total || i_dut.i_props.fail_count != 0)
         stop_with_failure(error_text($sformatf("%0d rx_valid pulses for %0d frames",
                                                valid_count, received_total)));
      else
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

//--- tx_fifo.sv
// Transmit byte queue module.
`timescale 1ns/1ps

module tx_fifo
   (
      input  logic       clk,
      input  logic       reset,
      input  logic       wr,
      input  logic [7:0] wr_data,
      input  logic       pop,
      output logic [7:0] head,
      output logic       empty,
      output logic       full
   );
   import uart_pkg::*;

   logic [7:0]       mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign wr_en = wr && !full;   // Writes while full are dropped.
   assign rd_en = pop && !empty;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= next_ptr(wr_ptr);
         if (rd_en)
            rd_ptr <= next_ptr(rd_ptr);
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= wr_data;
   end

   assign head  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == CNT_W'(FIFO_DEPTH));

endmodule

//--- uart_pkg.sv
// UART package with frame constants, counter widths, the state enum and the receive result struct.
package uart_pkg;

   localparam int DATA_BITS  = 8;    // Data bits per frame.
   localparam int OVERSAMPLE = 16;   // Ticks per bit.
   localparam int STOP_TICKS = 16;   // Ticks in the stop bit.
   localparam int TICK_DIV   = 4;    // Clock cycles per tick.
   localparam int FIFO_DEPTH = 4;    // Transmit queue depth.

   // Counter widths derived from the constants above.
   localparam int DIV_W      = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
   localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
   localparam int BIT_CNT_W  = $clog2(DATA_BITS);
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

   // Shared by the transmitter and the receiver.
   typedef enum logic [1:0]
   {
      idle,
      start,
      data,
      stop
   } uart_state_t;

   // One received frame as seen by the host.
   typedef struct packed
   {
      logic [DATA_BITS-1:0] data;
      logic                 frame_err;
   } rx_result_t;

endpackage

//--- uart_properties.sv
// Concurrent assertions on the UART top level and the bind that attaches them.
`timescale 1ns/1ps

module uart_properties
   (
      input logic                  clk,
      input logic                  reset,
      input logic                  tx,
      input logic                  full,
      input logic                  rx_valid,
      input uart_pkg::uart_state_t tx_state
   );
   import uart_pkg::*;

   int fail_count = 0;   // Failed checks so far.

   quiet_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> (tx && !rx_valid && !full) ##1 (tx && !rx_valid && !full)
                       ##1 (tx && !rx_valid && !full))
   else
   begin
      fail_count = fail_count + 1;
      $error("Line, receive output or full not quiet after reset.");
   end

   valid_is_pulse: assert property (@(posedge clk) disable iff (reset)
      rx_valid |=> !rx_valid)
   else
   begin
      fail_count = fail_count + 1;
      $error("rx_valid high for two cycles in a row.");
   end

   idle_line_high: assert property (@(posedge clk) disable iff (reset)
      (tx_state == idle) |-> tx)
   else
   begin
      fail_count = fail_count + 1;
      $error("tx low while the transmitter is idle.");
   end

endmodule

bind uart_top uart_properties i_props
(
   .clk      (clk),
   .reset    (reset),
   .tx       (tx),
   .full     (full),
   .rx_valid (rx_valid),
   .tx_state (i_uart_tx.state_reg)
);

//--- uart_rx.sv
// UART receiver module with 16x oversampling and stop bit check.
`timescale 1ns/1ps

module uart_rx
   (
      input  logic                 clk,
      input  logic                 reset,
      input  logic                 tick,
      input  logic                 rx,
      output uart_pkg::rx_result_t result,
      output logic                 valid
   );
   import uart_pkg::*;

   uart_state_t           state_reg, state_next;
   logic [TICK_CNT_W-1:0] s_reg, s_next;
   logic [BIT_CNT_W-1:0]  n_reg, n_next;
   logic [DATA_BITS-1:0]  b_reg;
   logic                  hold_reg, hold_next;   // Stop bit taken, waiting for a high line.
   logic                  rx_meta;
   logic                  rx_sync;
   logic                  shift_en;
   logic                  done;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rx_meta   <= 1'b1;
         rx_sync   <= 1'b1;
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
         hold_reg  <= 1'b0;
         valid     <= 1'b0;
      end
      else
      begin
         rx_meta   <= rx;
         rx_sync   <= rx_meta;
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         hold_reg  <= hold_next;
         valid     <= done;
      end
   end

   always_ff @(posedge clk)
   begin
      if (shift_en)
         b_reg <= {rx_sync, b_reg[DATA_BITS-1:1]};
      if (done)
      begin
         result.data      <= b_reg;
         result.frame_err <= ~rx_sync;   // A low stop bit is a framing error.
      end
   end

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      hold_next  = hold_reg;
      shift_en   = 1'b0;
      done       = 1'b0;
      case (state_reg)
         idle:
            if (!rx_sync)
            begin
               s_next     = '0;
               state_next = start;
            end
         start:
            if (tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE / 2 - 1))
               begin
                  s_next     = '0;
                  n_next     = '0;
                  state_next = rx_sync ? idle : data;   // A short glitch is not a start bit.
               end
               else
                  s_next = s_reg + 1'b1;
            end
         data:
            if (tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE - 1))
               begin
                  s_next   = '0;
                  shift_en = 1'b1;
                  if (n_reg == BIT_CNT_W'(DATA_BITS - 1))
                     state_next = stop;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         stop:
            if (hold_reg)
            begin
               if (rx_sync)
               begin
                  hold_next  = 1'b0;
                  state_next = idle;
               end
            end
            else if (tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE - 1))
               begin
                  done = 1'b1;
                  if (rx_sync)
                     state_next = idle;
                  else
                     hold_next = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         default:
            state_next = idle;
      endcase
   end

endmodule

//--- uart_top.sv
// UART core top level with tick generator, transmit queue, transmitter and receiver.
`timescale 1ns/1ps

module uart_top
   (
      input  logic                 clk,
      input  logic                 reset,
      input  logic                 wr,
      input  logic [7:0]           wr_data,
      output logic                 full,
      output logic                 tx,
      input  logic                 rx,
      output uart_pkg::rx_result_t rx_result,
      output logic                 rx_valid
   );

   logic       tick;
   logic [7:0] head;
   logic       empty;
   logic       pop;

   baud_gen i_baud_gen
   (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   tx_fifo i_tx_fifo
   (
      .clk     (clk),
      .reset   (reset),
      .wr      (wr),
      .wr_data (wr_data),
      .pop     (pop),
      .head    (head),
      .empty   (empty),
      .full    (full)
   );

   uart_tx i_uart_tx
   (
      .clk   (clk),
      .reset (reset),
      .tick  (tick),
      .empty (empty),
      .head  (head),
      .pop   (pop),
      .tx    (tx)
   );

   uart_rx i_uart_rx
   (
      .clk    (clk),
      .reset  (reset),
      .tick   (tick),
      .rx     (rx),
      .result (rx_result),
      .valid  (rx_valid)
   );

endmodule

//--- uart_tx.sv
// UART transmitter module with start, data and stop state machine.
`timescale 1ns/1ps

module uart_tx
   (
      input  logic       clk,
      input  logic       reset,
      input  logic       tick,
      input  logic       empty,
      input  logic [7:0] head,
      output logic       pop,
      output logic       tx
   );
   import uart_pkg::*;

   uart_state_t           state_reg, state_next;
   logic [TICK_CNT_W-1:0] s_reg, s_next;
   logic [BIT_CNT_W-1:0]  n_reg, n_next;
   logic [DATA_BITS-1:0]  b_reg, b_next;
   logic                  tx_next;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
         tx        <= 1'b1;   // Line idles high.
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx        <= tx_next;
      end
   end

   always_ff @(posedge clk)
   begin
      b_reg <= b_next;
   end

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      pop        = 1'b0;
      case (state_reg)
         idle:
            if (!empty)
            begin
               pop        = 1'b1;
               b_next     = head;
               s_next     = '0;
               state_next = start;
            end
         start:
            if (tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE - 1))
               begin
                  s_next     = '0;
                  n_next     = '0;
                  state_next = data;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         data:
            if (tick)
            begin
               if (s_reg == TICK_CNT_W'(OVERSAMPLE - 1))
               begin
                  s_next = '0;
                  b_next = b_reg >> 1;   // Least significant bit goes first.
                  if (n_reg == BIT_CNT_W'(DATA_BITS - 1))
                     state_next = stop;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
            end
         stop:
            if (tick)
            begin
               if (s_reg == TICK_CNT_W'(STOP_TICKS - 1))
                  state_next = idle;
               else
                  s_next = s_reg + 1'b1;
            end
         default:
            state_next = idle;
      endcase

      // The line level follows the next state so tx lines up with state_reg.
      case (state_next)
         start:   tx_next = 1'b0;
         data:    tx_next = b_next[0];
         default: tx_next = 1'b1;
      endcase
   end

endmodule
